/* kcpu_ctrl.f */
rtl/kcpu_isa_pkg.sv
rtl/kcpu_ucode_pkg.sv
rtl/kcpu_opcat_dec.sv
rtl/kcpu_ucode_rom.sv
rtl/kcpu_ucode_seq.sv
rtl/kcpu_ctrl.sv
dv/kcpu_ctrl_props.sv
dv/kcpu_ctrl_tb.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal -j 0
TOP       := kcpu_ctrl_tb
FILELIST  := kcpu_ctrl.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := test passed
RUN_ARGS  := +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/kcpu_ctrl_tb.sv */
`default_nettype none

module kcpu_ctrl_tb
    import kcpu_isa_pkg::*, kcpu_ucode_pkg::*;
;

    localparam int OP_DEPTH = 2;
    localparam int PERIOD   = 40;
    localparam int TEST_CYC = 300;  // random cycles per test
    localparam int N_TESTS  = 6;
    localparam int WATCHDOG = N_TESTS * TEST_CYC * 4 * PERIOD;
    localparam int K_STEP   = 0;    // model next-line kinds
    localparam int K_BOUND  = 1;
    localparam int K_HALT   = 2;

    logic        clk, rst, cen, op_valid, op_credit;
    logic        branch, alu_busy, mem_busy, irq, firq, nmi;
    op_xfer_t    op;
    ucode_ctrl_t ctrl;
    logic        ctrl_valid, int_active, halted;
    upc_t        upc;

    int         seed = 12355;
    int         errors, checks, tests, credits;
    logic [7:0] legal_ops[$];

    // reference model state
    upc_t       m_upc, m_addr;  // word on the rom output, next step address
    logic       m_pend, m_int, m_halt, m_credit;
    int         m_kind, m_ret, ack_cat;
    logic [7:0] m_q[$];          // opcodes pushed and not yet popped

    kcpu_ctrl #(
        .OP_DEPTH (OP_DEPTH)
    ) kcpu_ctrl_inst (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .op_valid   (op_valid),
        .op         (op),
        .op_credit  (op_credit),
        .branch     (branch),
        .alu_busy   (alu_busy),
        .mem_busy   (mem_busy),
        .irq        (irq),
        .firq       (firq),
        .nmi        (nmi),
        .ctrl       (ctrl),
        .ctrl_valid (ctrl_valid),
        .upc        (upc),
        .int_active (int_active),
        .halted     (halted)
    );

    bind kcpu_ucode_seq kcpu_ctrl_props #(
        .OP_DEPTH (OP_DEPTH)
    ) props_inst (
        .clk        (clk),
        .rst        (rst),
        .op_valid   (op_valid),
        .q_full     (q_full),
        .op_credit  (op_credit),
        .pend       (pend),
        .ctrl_valid (ctrl_valid),
        .halted     (halted),
        .cur_upc    (cur_upc)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    function automatic int rnd(input int n);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return r % n;
    endfunction

    function automatic bit chance(input int pct);
        return rnd(100) < pct;
    endfunction

    // category table of the reduced isa
    function automatic int op_cat(input logic [7:0] o);
        case (o)
            LDA_IMM, LDB_IMM, ADDA_IMM, ADDB_IMM,
            SUBA_IMM, CMPA_IMM, ANDA_IMM, ORA_IMM: return SINGLE_ALU;
            LDD_IMM, ADDD_IMM, SUBD_IMM, LDX_IMM:  return SINGLE_ALU16;
            LDA_IDX, LDB_IDX, ADDA_IDX, ADDB_IDX:  return SINGLE_ALU_IDX;
            LDD_IDX, ADDD_IDX, LDX_IDX:            return SINGLE_ALU_IDX16;
            LSRA, LSRB, RORA, ASLA, MUL:           return MULTI_ALU;
            BRA, BNE, BEQ, BCC:                    return SBRANCH;
            LBRA, LBSR:                            return LBRANCH;
            JMP:                                   return JUMP;
            JSR:                                   return JMSR;
            RTS:                                   return RTSR;
            PSHS:                                  return PSH;
            PULS:                                  return PUL;
            NOP:                                   return NOPE;
            STA, STB:                              return STORE8;
            STD, STX:                              return STORE16;
            default:                               return BUS_ERROR;
        endcase
    endfunction

    // indexed addressing modes take the ea pass first
    function automatic bit op_idx(input logic [7:0] o);
        case (o)
            LDA_IDX, LDB_IDX, ADDA_IDX, ADDB_IDX, LDD_IDX, ADDD_IDX, LDX_IDX,
            JMP, JSR, STA, STB, STD, STX: return 1'b1;
            default:                      return 1'b0;
        endcase
    endfunction

    function automatic upc_t base_of(input int cat);
        return upc_t'(cat << 4); // 16 lines per routine
    endfunction

    // expected rom line where unused lines halt
    function automatic ucode_word_u rom_line(input upc_t a);
        routine_t    r;
        ucode_word_u w;
        r        = routine_table(opcat_e'(a[UCODE_AW-1:4]));
        w        = '0;
        w.c.halt = 1'b1;
        if (int'(a[3:0]) < int'(r.len)) w = r.w[a[3:0]];
        return w;
    endfunction

    // mode 0 non-indexed, 1 indexed, 2 branch and multi-cycle alu, 3 any
    function automatic logic [7:0] pick_op(input int mode, input int bad_pct);
        logic [7:0] o;
        bit         ok;
        if (chance(bad_pct)) return chance(50) ? 8'h01 : 8'hFF; // not in the map
        do begin
            o = legal_ops[rnd(legal_ops.size())];
            case (mode)
                0:       ok = !op_idx(o);
                1:       ok = op_idx(o);
                2:       ok = op_cat(o) inside {MULTI_ALU, SBRANCH, LBRANCH};
                default: ok = 1'b1;
            endcase
        end while (!ok);
        return o;
    endfunction

    task automatic model_reset();
        m_q.delete();
        m_upc    = '0;
        m_addr   = '0;
        m_pend   = 1'b0;
        m_int    = 1'b0;
        m_halt   = 1'b0;
        m_credit = 1'b0;
        m_kind   = K_BOUND; // first line from the queue
        m_ret    = 0;
        ack_cat  = -1;
    endtask

    // one clock of the reference model on the inputs held through the cycle
    task automatic model_step();
        ucode_word_u w;
        logic        issue, int_req, go, leave;
        upc_t        tgt;
        int          cat;
        w        = rom_line(m_upc);
        cat      = int'(m_upc[UCODE_AW-1:4]);
        issue    = cen && !mem_busy && !m_halt;
        int_req  = !m_int && (nmi || firq || irq);
        leave    = m_pend && !w.c.fmt && w.c.ni
                && (cat inside {IRQ_ENTRY, FIRQ_ENTRY, NMI_ENTRY});
        go       = 1'b0;
        tgt      = '0;
        m_credit = 1'b0;
        if (m_pend) begin
            m_kind = K_STEP;
            m_addr = upc_t'(m_upc + 1'b1);
            if (w.j.fmt) begin
                if (w.j.jcond == J_ALWAYS || (w.j.jcond == J_BRANCH && branch)
                    || (w.j.jcond == J_ALUBUSY && alu_busy))
                    m_addr = {m_upc[UCODE_AW-1:4], w.j.target};
            end else if (w.c.halt) begin
                m_kind = K_HALT;
                if (cat == BUS_ERROR) m_halt = 1'b1;
            end else if (w.c.ret) begin
                m_addr = base_of(m_ret); // back from the ea pass
            end else if (w.c.ni) begin
                m_kind = K_BOUND;
            end
        end
        if (leave) m_int = 1'b0;
        if (issue && m_kind == K_STEP) begin
            go  = 1'b1;
            tgt = m_addr;
        end else if (issue && m_kind == K_BOUND && int_req) begin
            go      = 1'b1;
            ack_cat = nmi ? NMI_ENTRY : (firq ? FIRQ_ENTRY : IRQ_ENTRY);
            tgt     = base_of(ack_cat);
            m_int   = 1'b1;
        end else if (issue && m_kind == K_BOUND && m_q.size() > 0) begin
            go       = 1'b1;
            cat      = op_cat(m_q[0]);
            tgt      = op_idx(m_q[0]) ? base_of(IDX_FETCH) : base_of(cat);
            if (op_idx(m_q[0])) m_ret = cat;
            void'(m_q.pop_front());
            m_credit = 1'b1;
        end
        if (op_valid) m_q.push_back(op.opcode); // pushed after the pop as in hardware
        m_pend = go;
        if (go) m_upc = tgt;
    endtask

    always @(posedge clk) begin
        if (rst) model_reset();
        else     model_step();
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_outputs();
        ucode_word_u w;
        logic        exp_valid;
        w         = rom_line(m_upc);
        exp_valid = m_pend && !w.c.fmt; // jump words stay internal
        check_val("ctrl_valid", 32'(ctrl_valid), 32'(exp_valid));
        check_val("int_active", 32'(int_active), 32'(m_int));
        check_val("halted", 32'(halted), 32'(m_halt));
        check_val("op_credit", 32'(op_credit), 32'(m_credit));
        if (exp_valid) begin
            check_val("upc", 32'(upc), 32'(m_upc));
            check_val("ctrl", 32'(ctrl), 32'(w.c));
        end
    endtask

    // check at the falling edge, then take back credits and drive the next cycle
    task automatic one_cycle(input int mode, input int stall, input bit ints,
                             input int bad, input bit feed);
        @(negedge clk);
        compare_outputs();
        if (op_credit) credits++;
        op_valid = 1'b0;
        if (feed && credits > 0 && chance(60)) begin
            op_valid  = 1'b1;
            op.opcode = opcode_e'(pick_op(mode, bad));
            credits--;
        end
        cen      = !chance(stall / 2);
        mem_busy = chance(stall);
        branch   = chance(50);
        alu_busy = chance(40);
        if (ack_cat == NMI_ENTRY)  nmi = 1'b0;  // source drops once taken
        if (ack_cat == FIRQ_ENTRY) firq = 1'b0;
        if (ack_cat == IRQ_ENTRY)  irq = 1'b0;
        ack_cat = -1;
        if (ints && !nmi && !firq && !irq && chance(4)) begin
            nmi  = 1'b1; // all three together
            firq = 1'b1;
            irq  = 1'b1;
        end
    endtask

    function automatic bit model_idle();
        return m_q.size() == 0 && !op_valid && !m_pend && m_kind == K_BOUND
            && !m_int && !nmi && !firq && !irq;
    endfunction

    task automatic run_test(input string name, input int mode, input int stall, input bit ints);
        int e0;
        e0 = errors;
        repeat (TEST_CYC) one_cycle(mode, stall, ints, 0, 1);
        while (!model_idle()) one_cycle(mode, 0, 0, 0, 0); // drain
        check_val("credits", 32'(credits), 32'(OP_DEPTH));
        $display("%s finished, %0d errors", name, errors - e0);
        tests++;
    endtask

    task automatic apply_reset();
        rst      = 1'b1;
        cen      = 1'b0;
        op_valid = 1'b0;
        op       = '0;
        branch   = 1'b0;
        alu_busy = 1'b0;
        mem_busy = 1'b0;
        irq      = 1'b0;
        firq     = 1'b0;
        nmi      = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst     = 1'b0;
        credits = OP_DEPTH; // fetch starts full
    endtask

    initial begin
        opcode_e     e;
        int          e0;
        int unsigned total;
        errors = 0;
        checks = 0;
        tests  = 0;
        e      = e.first();
        do begin
            legal_ops.push_back(e);
            e = e.next();
        end while (e != e.first());
        apply_reset();
        run_test("non-indexed opcodes", 0, 0, 1'b0);
        run_test("indexed opcodes", 1, 0, 1'b0);
        run_test("branch and alu busy jumps", 2, 0, 1'b0);
        run_test("memory stalls and clock enable", 3, 40, 1'b0);
        run_test("interrupt entry", 3, 20, 1'b1);
        e0 = errors;
        while (!m_halt) one_cycle(3, 20, 0, 10, 1);
        repeat (20) one_cycle(3, 20, 1, 0, 1);  // must stay quiet
        apply_reset();
        repeat (4) one_cycle(3, 0, 0, 0, 0);
        $display("illegal opcode halt finished, %0d errors", errors - e0);
        tests++;
        total = errors + kcpu_ctrl_inst.ucode_seq_inst.props_inst.fails;
        $display("tests %0d, checks %0d, errors %0d", tests, checks, total);
        if (total == 0) $display("test passed");
        else            $display("test failed");
        $finish;
    end

    initial begin
        #(WATCHDOG);
        $display("watchdog expired, the tests did not complete in time");
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/kcpu_ctrl_props.sv */
`default_nettype none

module kcpu_ctrl_props
    import kcpu_isa_pkg::*, kcpu_ucode_pkg::*;
#(
    parameter int OP_DEPTH = 2
) (
    input wire  clk,
    input wire  rst,
    input wire  op_valid,
    input wire  q_full,
    input wire  op_credit,
    input wire  pend,       // rom word present
    input wire  ctrl_valid,
    input wire  halted,
    input upc_t cur_upc
);

    int unsigned fails = 0; // failed assertions, summed into the testbench error count
    logic [4:0]  cur_len;   // length of the routine being read
    int          held;      // credits fetch holds by its own count

    always_comb begin
        routine_t r;
        r       = routine_table(opcat_e'(cur_upc[UCODE_AW-1:4]));
        cur_len = r.len;
    end

    // each push spends one, each returned pulse gives one back
    always_ff @(posedge clk) begin
        if (rst) begin
            held <= OP_DEPTH;
        end else begin
            held <= held - int'(op_valid) + int'(op_credit);
        end
    end

    // fetch may only push while holding a credit
    a_no_full_push: assert property (@(posedge clk) disable iff (rst)
        !(op_valid && q_full))
        else begin
            $error("opcode pushed into a full queue");
            fails++;
        end

    a_quiet_halt: assert property (@(posedge clk) disable iff (rst)
        halted |-> !ctrl_valid)
        else begin
            $error("control word issued while halted");
            fails++;
        end

    // step must stay inside the routine
    a_step_range: assert property (@(posedge clk) disable iff (rst)
        pend |-> (cur_upc[3:0] < cur_len))
        else begin
            $error("microcode step beyond routine length");
            fails++;
        end

    // more credits back than opcodes taken would push fetch above the depth
    a_credit_bound: assert property (@(posedge clk) disable iff (rst)
        held <= OP_DEPTH)
        else begin
            $error("more credits returned than opcodes popped");
            fails++;
        end

endmodule

`default_nettype wire

/* rtl/kcpu_ctrl.sv */
`default_nettype none

module kcpu_ctrl
    import kcpu_isa_pkg::*, kcpu_ucode_pkg::*;
#(
    parameter int OP_DEPTH = 2 // opcode queue depth = initial credits
) (
    input  wire         clk,
    input  wire         rst,
    input  wire         cen,
    input  wire         op_valid,
    input  op_xfer_t    op,
    output logic        op_credit,
    input  wire         branch,
    input  wire         alu_busy,
    input  wire         mem_busy,
    input  wire         irq,
    input  wire         firq,
    input  wire         nmi,
    output ucode_ctrl_t ctrl,
    output logic        ctrl_valid,
    output upc_t        upc,
    output logic        int_active,
    output logic        halted
);

    opcode_e     head_op;
    dec_t        dec;
    logic        rd_en;
    upc_t        rd_addr;
    ucode_word_u rd_word;

    kcpu_opcat_dec opcat_dec_inst (
        .op  (head_op),
        .dec (dec)
    );

    kcpu_ucode_seq #(
        .OP_DEPTH (OP_DEPTH)
    ) ucode_seq_inst (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .op_valid   (op_valid),
        .op         (op),
        .op_credit  (op_credit),
        .dec        (dec),
        .head_op    (head_op),
        .branch     (branch),
        .alu_busy   (alu_busy),
        .mem_busy   (mem_busy),
        .irq        (irq),
        .firq       (firq),
        .nmi        (nmi),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_word    (rd_word),
        .ctrl       (ctrl),
        .ctrl_valid (ctrl_valid),
        .upc        (upc),
        .int_active (int_active),
        .halted     (halted)
    );

    kcpu_ucode_rom ucode_rom_inst (
        .clk     (clk),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_word (rd_word)
    );

endmodule

`default_nettype wire

/* rtl/kcpu_ucode_seq.sv */
`default_nettype none

module kcpu_ucode_seq
    import kcpu_isa_pkg::*, kcpu_ucode_pkg::*;
#(
    parameter int OP_DEPTH = 2
) (
    input  wire         clk,
    input  wire         rst,
    input  wire         cen,
    input  wire         op_valid,
    input  op_xfer_t    op,
    output logic        op_credit,  // one pulse per pop
    input  dec_t        dec,
    output opcode_e     head_op,
    input  wire         branch,
    input  wire         alu_busy,
    input  wire         mem_busy,
    input  wire         irq,
    input  wire         firq,
    input  wire         nmi,
    output logic        rd_en,
    output upc_t        rd_addr,
    input  ucode_word_u rd_word,
    output ucode_ctrl_t ctrl,
    output logic        ctrl_valid,
    output upc_t        upc,
    output logic        int_active,
    output logic        halted
);

    localparam int PW = (OP_DEPTH > 1) ? $clog2(OP_DEPTH) : 1;
    localparam int CW = $clog2(OP_DEPTH + 1);

    typedef enum logic [1:0] {K_STEP, K_BOUND, K_HALT} kind_e;

    opcode_e      q [OP_DEPTH];
    logic [PW-1:0] wr_ptr, rd_ptr;
    logic [CW-1:0] q_cnt;
    logic         q_empty, q_full, push, pop;

    logic   pend;             // rom word present this cycle
    upc_t   cur_upc;          // its address
    opcat_e cur_cat, ret_cat; // ret_cat saved for indexed pass
    kind_e  sv_kind, nxt_kind;
    upc_t   sv_addr, nxt_addr;
    logic   jmp_ok, can_issue, int_go, int_enter, int_leave;

    assign q_empty = (q_cnt == '0);
    assign q_full  = (q_cnt == CW'(OP_DEPTH));
    assign push    = op_valid && !q_full; // credits keep this from dropping
    assign head_op = q[rd_ptr];
    assign cur_cat = opcat_e'(cur_upc[UCODE_AW-1:4]);

    // what follows the present word, or the held decision while stalled
    always_comb begin
        nxt_kind = sv_kind;
        nxt_addr = sv_addr;
        jmp_ok   = 1'b0;
        if (pend) begin
            if (rd_word.j.fmt) begin
                case (rd_word.j.jcond)
                    J_ALWAYS:  jmp_ok = 1'b1;
                    J_BRANCH:  jmp_ok = branch;
                    J_ALUBUSY: jmp_ok = alu_busy;
                    default:   jmp_ok = 1'b0;
                endcase
                nxt_kind = K_STEP;
                nxt_addr = jmp_ok ? {cur_upc[UCODE_AW-1:4], rd_word.j.target}
                                  : upc_t'(cur_upc + 1'b1);
            end else if (rd_word.c.halt) begin
                nxt_kind = K_HALT;
            end else if (rd_word.c.ret) begin
                nxt_kind = K_STEP;
                nxt_addr = routine_base(ret_cat);
            end else if (rd_word.c.ni) begin
                nxt_kind = K_BOUND;
            end else begin
                nxt_kind = K_STEP;
                nxt_addr = upc_t'(cur_upc + 1'b1);
            end
        end
    end

    // issue and boundary target selection
    assign can_issue = cen && !mem_busy && !halted;
    assign int_go    = !int_active && (nmi || firq || irq);
    assign int_enter = can_issue && (nxt_kind == K_BOUND) && int_go;
    assign pop       = can_issue && (nxt_kind == K_BOUND) && !int_go && !q_empty;
    assign rd_en     = can_issue && ((nxt_kind == K_STEP) || int_enter || pop);

    always_comb begin
        rd_addr = nxt_addr;
        if (nxt_kind == K_BOUND) begin
            if (nmi)           rd_addr = routine_base(NMI_ENTRY); // nmi first
            else if (firq)     rd_addr = routine_base(FIRQ_ENTRY);
            else if (irq)      rd_addr = routine_base(IRQ_ENTRY);
            if (!int_go) begin // from the queue
                rd_addr = dec.idx_src ? routine_base(IDX_FETCH) : routine_base(dec.cat);
            end
        end
    end

    // entry routine finished at its own ni
    assign int_leave = pend && !rd_word.c.fmt && rd_word.c.ni
                    && (cur_cat inside {IRQ_ENTRY, FIRQ_ENTRY, NMI_ENTRY});

    assign ctrl       = rd_word.c;
    assign ctrl_valid = pend && !rd_word.c.fmt; // jump words stay internal
    assign upc        = cur_upc;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            q_cnt      <= '0;
            op_credit  <= 1'b0;
            pend       <= 1'b0;
            sv_kind    <= K_BOUND; // first line comes from the queue
            int_active <= 1'b0;
            halted     <= 1'b0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == PW'(OP_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            if (pop)  rd_ptr <= (rd_ptr == PW'(OP_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            q_cnt     <= q_cnt + CW'(push) - CW'(pop);
            op_credit <= pop;
            pend      <= rd_en;
            sv_kind   <= nxt_kind;
            if (int_enter)      int_active <= 1'b1;
            else if (int_leave) int_active <= 1'b0;
            if (pend && !rd_word.c.fmt && rd_word.c.halt && cur_cat == BUS_ERROR)
                halted <= 1'b1; // sticky until reset
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        sv_addr <= nxt_addr;
        if (push)                q[wr_ptr] <= op.opcode;
        if (rd_en)               cur_upc   <= rd_addr;
        if (pop && dec.idx_src)  ret_cat   <= dec.cat;
    end

endmodule

`default_nettype wire

/* rtl/kcpu_ucode_rom.sv */
`default_nettype none

module kcpu_ucode_rom
    import kcpu_isa_pkg::*, kcpu_ucode_pkg::*;
(
    input  wire         clk,
    input  wire         rd_en,   // issue strobe from sequencer
    input  upc_t        rd_addr,
    output ucode_word_u rd_word  // valid the cycle after rd_en
);

    localparam int DEPTH  = 2**UCODE_AW;
    localparam int N_ROUT = DEPTH / ROUTINE_LINES; // 64 routines

    ucode_word_u mem [DEPTH];

    // build store from the routine table
    initial begin
        routine_t r;
        for (int c = 0; c < N_ROUT; c++) begin
            r = routine_table(opcat_e'(c));
            for (int s = 0; s < ROUTINE_LINES; s++) begin
                if (s < int'(r.len))
                    mem[c*ROUTINE_LINES + s] = r.w[s];
                else
                    mem[c*ROUTINE_LINES + s] = cw(F_HLT); // never reached normally
            end
        end
    end

    // output register holds last word while idle
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_word <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

/* rtl/kcpu_opcat_dec.sv */
`default_nettype none

module kcpu_opcat_dec
    import kcpu_isa_pkg::*;
(
    input  opcode_e op,  // queue head
    output dec_t    dec
);

    opcat_e cat;
    logic   idx_src; // needs effective address before the routine

    // opcode to routine category
    always_comb begin
        case (op)
            LDA_IMM, LDB_IMM, ADDA_IMM, ADDB_IMM,
            SUBA_IMM, CMPA_IMM, ANDA_IMM, ORA_IMM:  cat = SINGLE_ALU;

            LDD_IMM, ADDD_IMM, SUBD_IMM, LDX_IMM:  cat = SINGLE_ALU16;

            LDA_IDX, LDB_IDX, ADDA_IDX, ADDB_IDX:  cat = SINGLE_ALU_IDX;

            LDD_IDX, ADDD_IDX, LDX_IDX:            cat = SINGLE_ALU_IDX16;

            LSRA, LSRB, RORA, ASLA, MUL:           cat = MULTI_ALU;

            BRA, BNE, BEQ, BCC:                    cat = SBRANCH;
            LBRA, LBSR:                            cat = LBRANCH;

            JMP:        cat = JUMP;
            JSR:        cat = JMSR;
            RTS:        cat = RTSR;
            PSHS:       cat = PSH;
            PULS:       cat = PUL;
            NOP:        cat = NOPE;

            STA, STB:      cat = STORE8;
            STD, STX:      cat = STORE16;
            default:       cat = BUS_ERROR; // illegal, stops the core
        endcase
    end

    // opcodes taking their operand through the indexed pass
    always_comb begin
        case (op)
            LDA_IDX, LDB_IDX, ADDA_IDX, ADDB_IDX,
            LDD_IDX, ADDD_IDX, LDX_IDX,
            JMP, JSR,
            STA, STB, STD, STX:  idx_src = 1'b1;
            default:             idx_src = 1'b0;
        endcase
    end

    assign dec.cat     = cat;
    assign dec.idx_src = idx_src;

endmodule

`default_nettype wire

/* rtl/kcpu_ucode_pkg.sv */
`default_nettype none

package kcpu_ucode_pkg;
    import kcpu_isa_pkg::*;

    localparam int UCODE_AW      = 10; // 1024 lines
    localparam int ROUTINE_LINES = 16; // 64 routines of 16

    typedef logic [UCODE_AW-1:0] upc_t; // {category, step}

    typedef enum logic [1:0] {J_ALWAYS, J_BRANCH, J_ALUBUSY} jcond_e;

    typedef struct packed {
        logic fmt; // 0 here
        logic alu_en, alu16, mem_rd, mem_wr;
        logic idx_go, psh_go, pul_go;
        logic ret;  // back to saved category
        logic ni;   // instruction boundary
        logic halt;
        logic [12:0] spare;
    } ucode_ctrl_t;

    typedef struct packed {
        logic        fmt;    // 1 here
        jcond_e      jcond;
        logic [3:0]  target; // step in same routine
        logic [16:0] spare;
    } ucode_jmp_t;

    typedef union packed {
        ucode_ctrl_t c;
        ucode_jmp_t  j;
    } ucode_word_u;

    typedef struct packed {
        logic [4:0]             len;
        ucode_word_u [ROUTINE_LINES-1:0] w;
    } routine_t;

    // control flag masks: alu_en..halt
    localparam logic [9:0] F_ALU = 10'h200, F_A16 = 10'h100, F_MRD = 10'h080;
    localparam logic [9:0] F_MWR = 10'h040, F_IDX = 10'h020, F_PSH = 10'h010;
    localparam logic [9:0] F_PUL = 10'h008, F_RET = 10'h004, F_NI  = 10'h002;
    localparam logic [9:0] F_HLT = 10'h001;

    function automatic ucode_word_u cw(input logic [9:0] f);
        ucode_word_u w;
        w = '0;
        {w.c.alu_en, w.c.alu16, w.c.mem_rd, w.c.mem_wr, w.c.idx_go,
         w.c.psh_go, w.c.pul_go, w.c.ret, w.c.ni, w.c.halt} = f;
        return w;
    endfunction

    function automatic ucode_word_u jw(input jcond_e c, input logic [3:0] t);
        ucode_word_u w;
        w         = '0;
        w.j.fmt   = 1'b1;
        w.j.jcond = c;
        w.j.target = t;
        return w;
    endfunction

    function automatic upc_t routine_base(input opcat_e c);
        return {c, 4'd0};
    endfunction

    // routine contents per category, len 0 = unused
    function automatic routine_t routine_table(input opcat_e c);
        routine_t r;
        r = '0;
        case (c)
            SINGLE_ALU, SINGLE_ALU_IDX: begin
                r.len = 2; r.w[0] = cw(F_MRD); r.w[1] = cw(F_ALU | F_NI);
            end
            SINGLE_ALU16, SINGLE_ALU_IDX16: begin
                r.len = 3; r.w[0] = cw(F_MRD); r.w[1] = cw(F_MRD);
                r.w[2] = cw(F_ALU | F_A16 | F_NI);
            end
            MULTI_ALU: begin // spin on alu_busy at step 1
                r.len = 3; r.w[0] = cw(F_ALU); r.w[1] = jw(J_ALUBUSY, 4'd1);
                r.w[2] = cw(F_ALU | F_NI);
            end
            SBRANCH: begin
                r.len = 4; r.w[0] = cw(F_MRD); r.w[1] = jw(J_BRANCH, 4'd3);
                r.w[2] = cw(F_NI); r.w[3] = cw(F_ALU | F_NI);
            end
            LBRANCH: begin
                r.len = 5; r.w[0] = cw(F_MRD); r.w[1] = cw(F_MRD);
                r.w[2] = jw(J_BRANCH, 4'd4); r.w[3] = cw(F_NI);
                r.w[4] = cw(F_ALU | F_A16 | F_NI);
            end
            JUMP: begin
                r.len = 1; r.w[0] = cw(F_ALU | F_A16 | F_NI);
            end
            JMSR: begin
                r.len = 3; r.w[0] = cw(F_PSH); r.w[1] = cw(F_MWR);
                r.w[2] = cw(F_MWR | F_ALU | F_A16 | F_NI);
            end
            RTSR: begin
                r.len = 3; r.w[0] = cw(F_PUL); r.w[1] = cw(F_MRD);
                r.w[2] = cw(F_MRD | F_NI);
            end
            PSH: begin
                r.len = 3; r.w[0] = cw(F_MRD); r.w[1] = cw(F_PSH | F_MWR);
                r.w[2] = cw(F_MWR | F_NI);
            end
            PUL: begin
                r.len = 3; r.w[0] = cw(F_MRD); r.w[1] = cw(F_PUL | F_MRD);
                r.w[2] = cw(F_MRD | F_NI);
            end
            NOPE:    begin r.len = 1; r.w[0] = cw(F_NI); end
            STORE8:  begin r.len = 1; r.w[0] = cw(F_MWR | F_NI); end
            STORE16: begin
                r.len = 2; r.w[0] = cw(F_MWR); r.w[1] = cw(F_MWR | F_NI);
            end
            IDX_FETCH: begin // postbyte, ea calc, wait, return
                r.len = 4; r.w[0] = cw(F_MRD); r.w[1] = cw(F_IDX);
                r.w[2] = jw(J_ALUBUSY, 4'd2); r.w[3] = cw(F_ALU | F_A16 | F_RET);
            end
            IRQ_ENTRY, NMI_ENTRY: begin // full stack frame
                r.len = 4; r.w[0] = cw(F_PSH | F_MWR); r.w[1] = cw(F_PSH | F_MWR);
                r.w[2] = cw(F_MRD); r.w[3] = cw(F_MRD | F_NI);
            end
            FIRQ_ENTRY: begin // short frame
                r.len = 3; r.w[0] = cw(F_PSH | F_MWR); r.w[1] = cw(F_MRD);
                r.w[2] = cw(F_MRD | F_NI);
            end
            BUS_ERROR: begin r.len = 1; r.w[0] = cw(F_HLT); end
            default:   r.len = 0;
        endcase
        return r;
    endfunction

endpackage

`default_nettype wire

/* rtl/kcpu_isa_pkg.sv */
`default_nettype none

package kcpu_isa_pkg;

    // reduced 6809-style opcode map
    typedef enum logic [7:0] {
        NOP      = 8'h12,
        LBRA     = 8'h16,
        LBSR     = 8'h17,
        BRA      = 8'h20,
        BCC      = 8'h24,
        BNE      = 8'h26,
        BEQ      = 8'h27,
        PSHS     = 8'h34,
        PULS     = 8'h35,
        RTS      = 8'h39,
        MUL      = 8'h3D,
        LSRA     = 8'h44,
        RORA     = 8'h46,
        ASLA     = 8'h48,
        LSRB     = 8'h54,
        JMP      = 8'h6E,
        SUBA_IMM = 8'h80,
        CMPA_IMM = 8'h81,
        SUBD_IMM = 8'h83,
        ANDA_IMM = 8'h84,
        LDA_IMM  = 8'h86,
        ORA_IMM  = 8'h8A,
        ADDA_IMM = 8'h8B,
        LDX_IMM  = 8'h8E,
        LDA_IDX  = 8'hA6,
        STA      = 8'hA7,
        ADDA_IDX = 8'hAB,
        JSR      = 8'hAD,
        LDX_IDX  = 8'hAE,
        STX      = 8'hAF,
        ADDD_IMM = 8'hC3,
        LDB_IMM  = 8'hC6,
        ADDB_IMM = 8'hCB,
        LDD_IMM  = 8'hCC,
        ADDD_IDX = 8'hE3,
        LDB_IDX  = 8'hE6,
        STB      = 8'hE7,
        ADDB_IDX = 8'hEB,
        LDD_IDX  = 8'hEC,
        STD      = 8'hED
    } opcode_e;

    // 0-31 instruction routines, 32 and up common routines
    typedef enum logic [5:0] {
        SINGLE_ALU = 6'd0, SINGLE_ALU16, SINGLE_ALU_IDX, SINGLE_ALU_IDX16,
        MULTI_ALU, SBRANCH, LBRANCH, JUMP, JMSR, RTSR, PSH, PUL, NOPE,
        STORE8, STORE16,
        IDX_FETCH = 6'd32, IRQ_ENTRY, FIRQ_ENTRY, NMI_ENTRY, BUS_ERROR
    } opcat_e;

    typedef struct packed {
        opcat_e cat;     // routine to run
        logic   idx_src; // indexed pass first
    } dec_t;

    typedef struct packed {
        opcode_e opcode; // pushed by fetch
    } op_xfer_t;

endpackage

`default_nettype wire
